//--- common/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data word and register file size
`define RV_XLEN 32
`define RV_NREGS 32

// first fetch address after reset
`define RV_RESET_VECTOR 32'h0000_0000

// pc step per instruction, in bytes
`define RV_INSTR_LEN 4

// wishbone data width
`define RV_BUS_WIDTH 8

`endif

//--- common/rv_pkg.sv
`default_nettype none

`include "rv_params.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t;
    typedef logic [`RV_BUS_WIDTH-1:0] byte_t;

    // instruction bits 6:2
    typedef enum logic [4:0] {
        LOAD    = 5'b00000,
        MISCMEM = 5'b00011,
        OPIMM   = 5'b00100,
        AUIPC   = 5'b00101,
        STORE   = 5'b01000,
        OP      = 5'b01100,
        LUI     = 5'b01101,
        BRANCH  = 5'b11000,
        JALR    = 5'b11001,
        JAL     = 5'b11011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    typedef enum logic [2:0] {
        READW, READB, READBU, WRITEW, WRITEB
    } bus_op_t;

    typedef enum logic [3:0] {
        RESET, FETCH, DECODE, EXEC, MEM, WB_ALU, WB_BUS, BRANCH2
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- common/mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// request channel from the control unit to the bus master, four-phase req/ack
interface mem_req_if;
    import rv_pkg::*;

    logic    req;
    bus_op_t op;
    word_t   addr;
    word_t   wdata;
    word_t   rdata;
    logic    ack;

    modport requester (output req, op, addr, wdata, input rdata, ack);
    modport responder (input req, op, addr, wdata, output rdata, ack);

endinterface

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire rv_pkg::word_t   a,
    input  wire rv_pkg::word_t   b,
    input  wire rv_pkg::alu_op_t op,
    output rv_pkg::word_t        result,
    output logic                 eq,
    output logic                 lt,
    output logic                 ltu
);
    import rv_pkg::*;

    logic [4:0] shamt;

    // only the low five bits count for shifts
    assign shamt = b[4:0];

    // compare flags, also used by branches
    assign eq  = (a == b);
    assign lt  = ($signed(a) < $signed(b));
    assign ltu = (a < b);

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = word_t'(lt);
            ALU_SLTU: result = word_t'(ltu);
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            // arithmetic shift keeps the sign bit
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = a + b;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  wire logic          clk,
    input  wire logic          load,
    input  wire rv_pkg::word_t instr,
    output rv_pkg::opcode_t    opcode,
    output rv_pkg::reg_addr_t  rd,
    output rv_pkg::reg_addr_t  rs1,
    output rv_pkg::reg_addr_t  rs2,
    output logic [2:0]         funct3,
    output logic               funct7_bit,
    output rv_pkg::word_t      imm
);
    import rv_pkg::*;

    opcode_t next_opcode;
    word_t   next_imm;

    assign next_opcode = opcode_t'(instr[6:2]);

    // immediate format follows the opcode
    always_comb begin
        case (next_opcode)
            STORE:
                next_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            BRANCH:
                next_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            LUI, AUIPC:
                next_imm = {instr[31:12], 12'b0};
            JAL:
                next_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            // I-type, also covers shift amounts
            default:
                next_imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    // fields held until the next fetch
    always_ff @(posedge clk) begin
        if (load) begin
            opcode     <= next_opcode;
            rd         <= instr[11:7];
            rs1        <= instr[19:15];
            rs2        <= instr[24:20];
            funct3     <= instr[14:12];
            funct7_bit <= instr[30];
            imm        <= next_imm;
        end
    end

endmodule

`default_nettype wire

//--- hw/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module regfile (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire rv_pkg::reg_addr_t rs1,
    input  wire rv_pkg::reg_addr_t rs2,
    input  wire rv_pkg::reg_addr_t rd,
    input  wire rv_pkg::word_t     wdata,
    input  wire logic              we,
    output rv_pkg::word_t          rdata1,
    output rv_pkg::word_t          rdata2
);
    import rv_pkg::*;

    // x0 has no storage
    word_t regs [1:`RV_NREGS-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- core/core_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module core_ctrl (
    input  wire logic            clk,
    input  wire logic            reset,
    mem_req_if.requester         mem,
    output logic                 dec_load,
    input  wire rv_pkg::opcode_t opcode,
    input  wire logic [2:0]      funct3,
    input  wire logic            funct7_bit,
    input  wire rv_pkg::word_t   imm,
    input  wire rv_pkg::word_t   reg_rdata1,
    input  wire rv_pkg::word_t   reg_rdata2,
    output logic                 reg_we,
    output rv_pkg::word_t        reg_wdata,
    output rv_pkg::word_t        alu_a,
    output rv_pkg::word_t        alu_b,
    output rv_pkg::alu_op_t      alu_op,
    input  wire rv_pkg::word_t   alu_result,
    input  wire logic            alu_eq,
    input  wire logic            alu_lt,
    input  wire logic            alu_ltu
);
    import rv_pkg::*;

    ctrl_state_t state;
    word_t       pc;
    word_t       pc_plus4;
    word_t       result_q;
    logic        taken_q;
    logic        branch_cond;
    logic        is_link;
    bus_op_t     mem_op;

    // funct3 to alu operation, funct7 bit only matters for sub and sra
    function automatic alu_op_t funct_op(input logic [2:0] f3, input logic f7,
                                         input logic reg_op);
        case (f3)
            3'b000:  return (reg_op && f7) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return f7 ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        case (funct3)
            3'b000:  branch_cond = alu_eq;
            3'b001:  branch_cond = !alu_eq;
            3'b100:  branch_cond = alu_lt;
            3'b101:  branch_cond = !alu_lt;
            3'b110:  branch_cond = alu_ltu;
            3'b111:  branch_cond = !alu_ltu;
            default: branch_cond = 1'b0;
        endcase
    end

    // operand muxes, rs1 and rs2 unless the state needs otherwise
    always_comb begin
        alu_a  = reg_rdata1;
        alu_b  = reg_rdata2;
        alu_op = ALU_ADD;
        case (state)
            DECODE: begin
                alu_a = pc;
                alu_b = word_t'(`RV_INSTR_LEN);
            end
            BRANCH2: begin
                alu_a = pc;
                alu_b = imm;
            end
            EXEC: begin
                case (opcode)
                    OP:    alu_op = funct_op(funct3, funct7_bit, 1'b1);
                    OPIMM: begin
                        alu_b  = imm;
                        alu_op = funct_op(funct3, funct7_bit, 1'b0);
                    end
                    LUI: begin
                        alu_a = '0;
                        alu_b = imm;
                    end
                    AUIPC, JAL: begin
                        alu_a = pc;
                        alu_b = imm;
                    end
                    LOAD, STORE, JALR: alu_b = imm;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    always_comb begin
        if (opcode == LOAD) begin
            case (funct3)
                3'b000:  mem_op = READB;
                3'b100:  mem_op = READBU;
                default: mem_op = READW;
            endcase
        end else begin
            mem_op = (funct3 == 3'b000) ? WRITEB : WRITEW;
        end
    end

    always_comb begin
        case (state)
            WB_BUS:  reg_wdata = mem.rdata;
            EXEC:    reg_wdata = pc_plus4;
            default: reg_wdata = result_q;
        endcase
    end

    assign is_link   = (opcode == JAL) || (opcode == JALR);
    assign reg_we    = (state == WB_ALU) || (state == WB_BUS) || ((state == EXEC) && is_link);
    assign dec_load  = (state == FETCH) && mem.req && mem.ack;
    assign mem.wdata = reg_rdata2;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= RESET;
            mem.req <= 1'b0;
        end else begin
            case (state)
                RESET: begin
                    pc    <= `RV_RESET_VECTOR;
                    state <= FETCH;
                end
                FETCH: begin
                    // wait for ack low before a new request
                    if (!mem.req && !mem.ack) begin
                        mem.req  <= 1'b1;
                        mem.op   <= READW;
                        mem.addr <= pc;
                    end else if (mem.req && mem.ack) begin
                        mem.req <= 1'b0;
                        state   <= DECODE;
                    end
                end
                DECODE: begin
                    pc_plus4 <= alu_result;
                    state    <= EXEC;
                end
                EXEC: begin
                    result_q <= alu_result;
                    taken_q  <= branch_cond;
                    // branch target still needs the old pc
                    if (opcode != BRANCH) begin
                        pc <= pc_plus4;
                    end
                    case (opcode)
                        OP, OPIMM, LUI, AUIPC: state <= WB_ALU;
                        LOAD, STORE:           state <= MEM;
                        BRANCH:                state <= BRANCH2;
                        JAL: begin
                            pc    <= alu_result;
                            state <= FETCH;
                        end
                        JALR: begin
                            pc    <= {alu_result[`RV_XLEN-1:1], 1'b0};
                            state <= FETCH;
                        end
                        // fence and unknown opcodes do nothing
                        default: state <= FETCH;
                    endcase
                end
                MEM: begin
                    if (!mem.req && !mem.ack) begin
                        mem.req  <= 1'b1;
                        mem.op   <= mem_op;
                        mem.addr <= result_q;
                    end else if (mem.req && mem.ack) begin
                        mem.req <= 1'b0;
                        state   <= (opcode == LOAD) ? WB_BUS : FETCH;
                    end
                end
                BRANCH2: begin
                    pc    <= taken_q ? alu_result : pc_plus4;
                    state <= FETCH;
                end
                default: state <= FETCH;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- bus/wb8_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module wb8_master (
    input  wire logic          clk,
    input  wire logic          reset,
    mem_req_if.responder       mem,
    output rv_pkg::word_t      adr,
    output rv_pkg::byte_t      dat_o_bus,
    input  wire rv_pkg::byte_t dat_i_bus,
    output logic               cyc,
    output logic               stb,
    output logic               we,
    input  wire logic          ack_bus
);
    import rv_pkg::*;

    localparam int LANES  = `RV_XLEN / `RV_BUS_WIDTH;
    localparam int LANE_W = $clog2(LANES);

    logic [LANE_W-1:0] lane;
    logic [LANE_W-1:0] last_lane;
    word_t             wr_shift;
    word_t             rd_shift;
    bus_op_t           op_q;
    logic              byte_op;

    assign byte_op   = (mem.op == READB) || (mem.op == READBU) || (mem.op == WRITEB);
    // low byte goes out first
    assign dat_o_bus = wr_shift[`RV_BUS_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            cyc     <= 1'b0;
            stb     <= 1'b0;
            we      <= 1'b0;
            lane    <= '0;
            mem.ack <= 1'b0;
        end else if (mem.ack) begin
            // hold ack until req is gone
            if (!mem.req) begin
                mem.ack <= 1'b0;
            end
        end else if (!cyc) begin
            if (mem.req) begin
                cyc       <= 1'b1;
                stb       <= 1'b1;
                we        <= (mem.op == WRITEW) || (mem.op == WRITEB);
                adr       <= mem.addr;
                wr_shift  <= mem.wdata;
                op_q      <= mem.op;
                lane      <= '0;
                last_lane <= byte_op ? '0 : LANE_W'(LANES - 1);
            end
        end else if (ack_bus) begin
            rd_shift <= {dat_i_bus, rd_shift[`RV_XLEN-1:`RV_BUS_WIDTH]};
            if (lane == last_lane) begin
                cyc     <= 1'b0;
                stb     <= 1'b0;
                we      <= 1'b0;
                mem.ack <= 1'b1;
                case (op_q)
                    READB:  mem.rdata <= {{(`RV_XLEN-`RV_BUS_WIDTH){dat_i_bus[`RV_BUS_WIDTH-1]}},
                                          dat_i_bus};
                    READBU: mem.rdata <= {{(`RV_XLEN-`RV_BUS_WIDTH){1'b0}}, dat_i_bus};
                    default: mem.rdata <= {dat_i_bus, rd_shift[`RV_XLEN-1:`RV_BUS_WIDTH]};
                endcase
            end else begin
                // next byte lane, cyc stays up
                lane     <= lane + 1'b1;
                adr      <= adr + 1'b1;
                wr_shift <= wr_shift >> `RV_BUS_WIDTH;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module cpu (
    input  wire logic                     clk,
    input  wire logic                     reset,
    output wire [`RV_XLEN-1:0]            adr,
    output wire [`RV_BUS_WIDTH-1:0]       dat_o_bus,
    input  wire logic [`RV_BUS_WIDTH-1:0] dat_i_bus,
    output wire                           cyc,
    output wire                           stb,
    output wire                           we,
    input  wire logic                     ack
);
    import rv_pkg::*;

    mem_req_if mem_bus ();

    // decoder fields
    logic      dec_load;
    opcode_t   dec_opcode;
    reg_addr_t dec_rd;
    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    logic [2:0] dec_funct3;
    logic      dec_funct7_bit;
    word_t     dec_imm;

    word_t     reg_rdata1;
    word_t     reg_rdata2;
    word_t     reg_wdata;
    logic      reg_we;

    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_result;
    alu_op_t   alu_op;
    logic      alu_eq;
    logic      alu_lt;
    logic      alu_ltu;

    alu alu_i (
        .a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result),
        .eq(alu_eq), .lt(alu_lt), .ltu(alu_ltu)
    );

    decoder decoder_i (
        .clk(clk), .load(dec_load), .instr(mem_bus.rdata),
        .opcode(dec_opcode), .rd(dec_rd), .rs1(dec_rs1), .rs2(dec_rs2),
        .funct3(dec_funct3), .funct7_bit(dec_funct7_bit), .imm(dec_imm)
    );

    regfile regfile_i (
        .clk(clk), .reset(reset), .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd),
        .wdata(reg_wdata), .we(reg_we), .rdata1(reg_rdata1), .rdata2(reg_rdata2)
    );

    core_ctrl core_ctrl_i (
        .clk(clk), .reset(reset), .mem(mem_bus.requester), .dec_load(dec_load),
        .opcode(dec_opcode), .funct3(dec_funct3), .funct7_bit(dec_funct7_bit),
        .imm(dec_imm), .reg_rdata1(reg_rdata1), .reg_rdata2(reg_rdata2),
        .reg_we(reg_we), .reg_wdata(reg_wdata), .alu_a(alu_a), .alu_b(alu_b),
        .alu_op(alu_op), .alu_result(alu_result), .alu_eq(alu_eq),
        .alu_lt(alu_lt), .alu_ltu(alu_ltu)
    );

    wb8_master wb8_master_i (
        .clk(clk), .reset(reset), .mem(mem_bus.responder), .adr(adr),
        .dat_o_bus(dat_o_bus), .dat_i_bus(dat_i_bus), .cyc(cyc), .stb(stb),
        .we(we), .ack_bus(ack)
    );

endmodule

`default_nettype wire

//--- testbench/cpu_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module cpu_assert (
    input wire logic                     clk,
    input wire logic                     reset,
    input wire logic [`RV_XLEN-1:0]      adr,
    input wire logic [`RV_BUS_WIDTH-1:0] dat_o_bus,
    input wire logic                     cyc,
    input wire logic                     stb,
    input wire logic                     we,
    input wire logic                     ack
);

    int fail_count = 0;

    stb_needs_cyc: assert property (@(posedge clk) disable iff (reset) stb |-> cyc)
        else begin
            fail_count++;
            $error("stb high without cyc");
        end

    // a byte cycle holds still until the device acks it
    hold_while_waiting: assert property (@(posedge clk) disable iff (reset)
        (stb && !ack) |=> ($stable(adr) && $stable(we) && $stable(dat_o_bus)))
        else begin
            fail_count++;
            $error("adr, we or dat_o_bus changed before ack");
        end

    cyc_low_in_reset: assert property (@(posedge clk) reset |=> !cyc)
        else begin
            fail_count++;
            $error("cyc high during reset");
        end

endmodule

bind cpu cpu_assert cpu_assert_i (
    .clk(clk), .reset(reset), .adr(adr), .dat_o_bus(dat_o_bus),
    .cyc(cyc), .stb(stb), .we(we), .ack(ack)
);

`default_nettype wire

//--- testbench/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module tb_checker #(
    parameter int EXP_MAX = 32
) (
    input wire logic                     clk,
    input wire logic                     reset,
    input wire logic [`RV_XLEN-1:0]      adr,
    input wire logic [`RV_BUS_WIDTH-1:0] dat_o_bus,
    input wire logic                     cyc,
    input wire logic                     stb,
    input wire logic                     we,
    input wire logic                     ack,
    input var rv_pkg::word_t             exp_addr [0:EXP_MAX-1],
    input var rv_pkg::word_t             exp_data [0:EXP_MAX-1],
    input var int                        exp_width [0:EXP_MAX-1],
    input var int                        exp_count,
    input var rv_pkg::word_t             done_addr,
    output logic                         done,
    output int                           value_errors,
    output int                           other_errors
);
    import rv_pkg::*;

    int    nbytes;
    int    exp_idx;
    logic  is_write;
    logic  seen_first;
    word_t start;
    word_t wval;

    task automatic close_store();
        if (start == done_addr) begin
            done = 1'b1;
            if (exp_idx != exp_count) begin
                other_errors++;
                $display("missing stores: only %0d of %0d expected stores came before the end",
                         exp_idx, exp_count);
            end
        end else if (exp_idx >= exp_count) begin
            other_errors++;
            $display("extra store of %h at address %h after all expected stores", wval, start);
        end else begin
            if (start != exp_addr[exp_idx] || nbytes != exp_width[exp_idx]
                    || wval != exp_data[exp_idx]) begin
                value_errors++;
                $display("[ERROR] %0t: store %0d wrote %h (%0dB) at %h, expected %h (%0dB) at %h",
                         $time, exp_idx, wval, nbytes, start, exp_data[exp_idx],
                         exp_width[exp_idx], exp_addr[exp_idx]);
            end
            exp_idx++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            nbytes       = 0;
            exp_idx      = 0;
            is_write     = 1'b0;
            seen_first   = 1'b0;
            done         = 1'b0;
            value_errors = 0;
            other_errors = 0;
        end else if (cyc && stb && ack) begin
            if (!seen_first) begin
                seen_first = 1'b1;
                if (adr != `RV_RESET_VECTOR) begin
                    other_errors++;
                    $display("first bus access went to %h instead of the reset vector", adr);
                end
            end
            if (nbytes == 0) begin
                start = adr;
                wval  = '0;
            end else if (adr != start + nbytes) begin
                other_errors++;
                $display("byte %0d of the transfer at %h used address %h", nbytes, start, adr);
            end
            // little endian so the first byte is the lowest
            if (we && nbytes < 4) begin
                wval[8*nbytes +: 8] = dat_o_bus;
            end
            is_write = we;
            nbytes++;
        end else if (!cyc && nbytes != 0) begin
            if (is_write) begin
                close_store();
            end else if (nbytes != 1 && nbytes != 4) begin
                other_errors++;
                $display("read at %h took %0d bytes", start, nbytes);
            end
            nbytes = 0;
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module tb_cpu;
    import rv_pkg::*;

    localparam int STIM_WORDS = 256;
    localparam int MEM_BYTES  = 512;
    localparam int EXP_MAX    = 32;

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     ack;
    logic [`RV_BUS_WIDTH-1:0] dat_i_bus;
    wire  [`RV_XLEN-1:0]      adr;
    wire  [`RV_BUS_WIDTH-1:0] dat_o_bus;
    wire                      cyc;
    wire                      stb;
    wire                      we;

    word_t stim [0:STIM_WORDS-1];
    byte_t mem [0:MEM_BYTES-1];
    word_t exp_addr [0:EXP_MAX-1];
    word_t exp_data [0:EXP_MAX-1];
    int    exp_width [0:EXP_MAX-1];
    int    exp_count;
    word_t done_addr;
    int    prog_lines;
    int    delay;
    int    cycles;
    int    limit;
    int    seed_ret;
    logic  timed_out;
    logic  done;
    int    value_errors;
    int    other_errors;
    int    stim_errors;
    int    assert_errors;

    cpu dut_i (
        .clk(clk), .reset(reset), .adr(adr), .dat_o_bus(dat_o_bus),
        .dat_i_bus(dat_i_bus), .cyc(cyc), .stb(stb), .we(we), .ack(ack)
    );

    tb_checker #(.EXP_MAX(EXP_MAX)) checker_i (
        .clk(clk), .reset(reset), .adr(adr), .dat_o_bus(dat_o_bus),
        .cyc(cyc), .stb(stb), .we(we), .ack(ack),
        .exp_addr(exp_addr), .exp_data(exp_data), .exp_width(exp_width),
        .exp_count(exp_count), .done_addr(done_addr), .done(done),
        .value_errors(value_errors), .other_errors(other_errors)
    );

    always #4 clk = ~clk;

    // byte memory that acks after 0 to 3 idle cycles
    initial begin
        seed_ret = $urandom(32'h1080_c73c);
        forever begin
            @(negedge clk);
            if (reset) begin
                ack   = 1'b0;
                delay = $urandom % 4;
            end else if (ack) begin
                ack   = 1'b0;
                delay = $urandom % 4;
            end else if (stb) begin
                if (delay == 0) begin
                    ack = 1'b1;
                    if (we) begin
                        mem[adr[8:0]] = dat_o_bus;
                    end else begin
                        dat_i_bus = mem[adr[8:0]];
                    end
                end else begin
                    delay--;
                end
            end
        end
    end

    task automatic load_stim();
        int i;
        i          = 0;
        exp_count  = 0;
        prog_lines = 0;
        done_addr  = '1;
        $readmemh("testbench/cpu_stim.txt", stim);
        while (i + 2 < STIM_WORDS && stim[i] != 0) begin
            case (stim[i])
                1: begin
                    for (int b = 0; b < 4; b++) begin
                        mem[(stim[i+1] + b) % MEM_BYTES] = stim[i+2][8*b +: 8];
                    end
                    prog_lines++;
                end
                2, 3: begin
                    exp_addr[exp_count]  = stim[i+1];
                    exp_data[exp_count]  = stim[i+2];
                    exp_width[exp_count] = (stim[i] == 2) ? 4 : 1;
                    exp_count++;
                end
                4: done_addr = stim[i+1];
                default: begin
                    stim_errors++;
                    $display("unknown record kind %0d in the stim file", stim[i]);
                end
            endcase
            i += 3;
        end
    endtask

    initial begin
        reset       = 1'b1;
        ack         = 1'b0;
        dat_i_bus   = '0;
        stim_errors = 0;
        // background pattern over the whole address
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem[a] = byte_t'(a ^ (a >> 8) ^ 8'h5a);
        end
        load_stim();
        limit = prog_lines * 80;
        repeat (3) @(negedge clk);
        reset  = 1'b0;
        cycles = 0;
        while (!done && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        timed_out = !done;
        if (timed_out) begin
            $display("timeout: no store to the done address within %0d cycles", limit);
        end
        repeat (2) @(negedge clk);
        assert_errors = dut_i.cpu_assert_i.fail_count;
        $display("errors: value %0d, other %0d, stim %0d, assertion %0d, timeout %0d",
                 value_errors, other_errors, stim_errors, assert_errors, timed_out);
        if (value_errors == 0 && other_errors == 0 && stim_errors == 0 && assert_errors == 0
                && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/cpu_stim.txt
// kind address data: 1 program word, 2 expected word store, 3 expected byte store
// 4 done address, 0 end of records
1 00000000 FFB00093
1 00000004 00300113
1 00000008 401101B3
1 0000000C 4020D233
1 00000010 0020A2B3
1 00000014 0020B333
1 00000018 10302023
1 0000001C 10402223
1 00000020 10502423
1 00000024 10602623
1 00000028 00710013
1 0000002C 10002823
1 00000030 12345437
1 00000034 10802A23
1 00000038 00001497
1 0000003C 10902C23
1 00000040 18002503
1 00000044 18000583
1 00000048 18004603
1 0000004C 10A02E23
1 00000050 12B02023
1 00000054 12C00223
// branch pairs, taken skips a bad store, not taken would land on it
1 00000058 00210463
1 0000005C 1E002823
1 00000060 FE208EE3
1 00000064 00209463
1 00000068 1E002823
1 0000006C FE211EE3
1 00000070 0020C463
1 00000074 1E002823
1 00000078 FE114EE3
1 0000007C 00115463
1 00000080 1E002823
1 00000084 FE20DEE3
1 00000088 00116463
1 0000008C 1E002823
1 00000090 FE20EEE3
1 00000094 0020F463
1 00000098 1E002823
1 0000009C FE117EE3
// jal and jalr links
1 000000A0 0080076F
1 000000A4 1E002823
1 000000A8 12E02423
1 000000AC 011707E7
1 000000B0 1E002823
1 000000B4 12F02623
1 000000B8 1E002E23
1 000000BC 0000006F
// load data
1 00000180 80F12385
2 00000100 00000008
2 00000104 FFFFFFFF
2 00000108 00000001
2 0000010C 00000000
2 00000110 00000000
2 00000114 12345000
2 00000118 00001038
2 0000011C 80F12385
2 00000120 FFFFFF85
3 00000124 00000085
2 00000128 000000A4
2 0000012C 000000B0
4 000001FC 00000000
0 00000000 00000000

//--- vlog.f
+incdir+common
common/rv_pkg.sv
common/mem_req_if.sv
hw/alu.sv
hw/decoder.sv
hw/regfile.sv
core/core_ctrl.sv
bus/wb8_master.sv
hw/cpu.sv
testbench/cpu_assert.sv
testbench/tb_checker.sv
testbench/tb_cpu.sv
